// ==== src.f ====
+incdir+hw
hw/mera_pkg.sv
hw/isk.sv
hw/bus_requester.sv
hw/mem_module.sv
hw/puks.sv
hw/mera_bus_top.sv
tb/mera_bus_properties.sv
tb/mera_bus_tb.sv

// ==== tb/mera_bus_tb.sv ====
`include "mera_defs.svh"

module mera_bus_tb import mera_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// expected end of one request
	typedef struct {
		cyc_status_t st;
		bus_word_t rd;
		logic is_rd;
	} exp_t;

	logic clk_sys;
	logic rst_n;
	logic clear;
	logic cpu_req, cpu_we, cpu_busy, cpu_done;
	seg_t cpu_nb;
	bus_word_t cpu_ad, cpu_dt, cpu_rdt;
	cyc_status_t cpu_status;
	logic ch_req, ch_we, ch_busy, ch_done;
	seg_t ch_nb;
	bus_word_t ch_ad, ch_dt, ch_rdt;
	cyc_status_t ch_status;
	logic clm;

	// model memory and pending expectations per port
	bus_word_t model [`MEM_SEGMENTS][2 ** `MEM_AW];
	exp_t cpu_q[$];
	exp_t ch_q[$];
	int cyc = 0;
	int cpu_done_cyc = 0;
	int ch_done_cyc = 0;
	int seed = 69579;

	mera_bus_top mera_bus_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// --------------------
	// reporting and checks
	// --------------------

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_status(input string name, input cyc_status_t got,
			input cyc_status_t exp);
		if (got !== exp)
			stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
		if (got !== exp)
			stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	// --------------------
	// reference model
	// --------------------

	// only present segments and page words answer and anything else times out
	function automatic exp_t ref_access(input logic we, input seg_t nb, input bus_word_t ad,
			input bus_word_t dt);
		exp_t e;
		e.st = CYC_ALARM;
		e.rd = '0;
		e.is_rd = 1'b0;
		if (int'(nb) < `MEM_SEGMENTS && int'(ad) < 2 ** `MEM_AW) begin
			e.st = CYC_OK;
			e.is_rd = !we;
			if (we)
				model[int'(nb)][int'(ad)] = dt;
			else
				e.rd = model[int'(nb)][int'(ad)];
		end
		return e;
	endfunction

	// compare at the falling edge where outputs have settled
	always begin
		exp_t e;
		@(negedge clk_sys);
		cyc++;
		if (mera_bus_top_i.isk_i.props_i.err_cnt != 0)
			stop_run("a bus property assertion failed");
		if (cpu_done === 1'b1) begin
			if (cpu_q.size() == 0)
				stop_run("processor port gave done with no request pending");
			e = cpu_q.pop_front();
			check_status("cpu_status", cpu_status, e.st);
			if (e.is_rd)
				check_word("cpu_rdt", cpu_rdt, e.rd);
			cpu_done_cyc = cyc;
		end
		if (ch_done === 1'b1) begin
			if (ch_q.size() == 0)
				stop_run("channel port gave done with no request pending");
			e = ch_q.pop_front();
			check_status("ch_status", ch_status, e.st);
			if (e.is_rd)
				check_word("ch_rdt", ch_rdt, e.rd);
			ch_done_cyc = cyc;
		end
	end

	// --------------------
	// stimulus helpers
	// --------------------

	// inputs move 1 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	// raise req on port 1 (processor) or port 2 (channel)
	task automatic post_req(input int port, input logic we, input seg_t nb, input bus_word_t ad,
			input bus_word_t dt);
		if (port == 1) begin
			{cpu_req, cpu_we, cpu_nb, cpu_ad, cpu_dt} = {1'b1, we, nb, ad, dt};
			cpu_q.push_back(ref_access(we, nb, ad, dt));
		end else begin
			{ch_req, ch_we, ch_nb, ch_ad, ch_dt} = {1'b1, we, nb, ad, dt};
			ch_q.push_back(ref_access(we, nb, ad, dt));
		end
	endtask

	task automatic wait_all_done();
		int n;
		n = 0;
		while (cpu_q.size() != 0 || ch_q.size() != 0) begin
			tick();
			n++;
			if (n > 4 * `BUS_TIMEOUT_TICKS)
				stop_run("timed out waiting for done");
		end
	endtask

	task automatic wait_clm_low();
		int n;
		n = 0;
		while (clm) begin
			tick();
			n++;
			if (n > 4 * `PUKS_CLR_TICKS)
				stop_run("clear period never ended");
		end
	endtask

	// single request with busy one cycle later
	task automatic run_one(input int port, input logic we, input seg_t nb, input bus_word_t ad,
			input bus_word_t dt);
		post_req(port, we, nb, ad, dt);
		tick();
		cpu_req = 1'b0;
		ch_req = 1'b0;
		check_flag(port == 1 ? "cpu_busy" : "ch_busy", port == 1 ? cpu_busy : ch_busy, 1'b1);
		wait_all_done();
	endtask

	// --------------------
	// test sequence
	// --------------------

	initial begin
		int n;
		logic [31:0] r;
		seg_t wr_nb [10];
		bus_word_t wr_ad [10];
		bus_word_t wr_dt [10];
		{rst_n, clear, cpu_req, cpu_we, cpu_nb, cpu_ad, cpu_dt} = '0;
		{ch_req, ch_we, ch_nb, ch_ad, ch_dt} = '0;
		for (int s = 0; s < `MEM_SEGMENTS; s++)
			for (int a = 0; a < 2 ** `MEM_AW; a++)
				model[s][a] = '0;
		repeat (5) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;

		// power-up clear length and a req dropped inside it
		n = 0;
		while (clm) begin
			cpu_req = (n == 3);
			check_flag("cpu_busy", cpu_busy, 1'b0);
			tick();
			n++;
			if (n > 4 * `PUKS_CLR_TICKS)
				stop_run("clm did not drop after the power-up clear");
		end
		cpu_req = 1'b0;
		if (n != `PUKS_CLR_TICKS)
			stop_run($sformatf("FAIL clm_ticks got %h expected %h", n, `PUKS_CLR_TICKS));
		repeat (4) begin
			tick();
			check_flag("cpu_busy", cpu_busy, 1'b0);
		end

		// writes to the low half of each page and reads back
		for (int i = 0; i < 10; i++) begin
			r = $random(seed);
			wr_nb[i] = seg_t'(r[0]);
			wr_ad[i] = {9'h000, r[14:8]};
			wr_dt[i] = r[31:16];
			run_one(1, 1'b1, wr_nb[i], wr_ad[i], wr_dt[i]);
		end
		for (int i = 0; i < 10; i++)
			run_one(1, 1'b0, wr_nb[i], wr_ad[i], '0);
		// high half never written
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			run_one(1, 1'b0, seg_t'(r[0]), {8'h00, 1'b1, r[14:8]}, '0);
		end

		// missing segment or address past the page
		run_one(1, 1'b0, 4'd2, 16'h0010, '0);
		run_one(1, 1'b1, 4'hf, 16'h0020, 16'h1234);
		run_one(1, 1'b0, 4'd0, 16'h0100, '0);
		run_one(1, 1'b1, 4'd1, 16'hffff, 16'h5678);

		// both ports at once with the processor first
		post_req(1, 1'b1, 4'd0, 16'h0033, 16'ha5a5);
		post_req(2, 1'b1, 4'd1, 16'h0044, 16'h5a5a);
		tick();
		{cpu_req, ch_req} = 2'b00;
		wait_all_done();
		if (cpu_done_cyc >= ch_done_cyc)
			stop_run("channel port finished before the processor port");
		post_req(1, 1'b0, 4'd1, 16'h0044, '0);
		post_req(2, 1'b0, 4'd0, 16'h0033, '0);
		tick();
		{cpu_req, ch_req} = 2'b00;
		wait_all_done();
		if (cpu_done_cyc >= ch_done_cyc)
			stop_run("channel port finished before the processor port");

		// panel clear aborts a write in flight without done
		{cpu_req, cpu_we, cpu_nb, cpu_ad, cpu_dt} = {1'b1, 1'b1, 4'd1, 16'h00c5, 16'hbeef};
		tick();
		cpu_req = 1'b0;
		check_flag("cpu_busy", cpu_busy, 1'b1);
		clear = 1'b1;
		tick();
		clear = 1'b0;
		tick();
		tick();
		check_flag("cpu_busy", cpu_busy, 1'b0);
		check_flag("clm", clm, 1'b1);
		wait_clm_low();
		// aborted write must not have landed
		run_one(1, 1'b0, 4'd1, 16'h00c5, '0);
		run_one(1, 1'b1, 4'd1, 16'h00c6, 16'h0f0f);
		run_one(2, 1'b0, 4'd1, 16'h00c6, '0);

		repeat (3) tick();
		if (cpu_q.size() != 0 || ch_q.size() != 0)
			stop_run("requests left without done at the end");
		else
			$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== tb/mera_bus_properties.sv ====
module mera_bus_properties (
	input logic clk_sys,
	input logic rst_n,
	input logic clm,
	input logic zg1,
	input logic zg2,
	input logic zw1,
	input logic zw2,
	input logic ok
);

	timeunit 1ns;
	timeprecision 100ps;

	// count of failed assertions
	int err_cnt = 0;

	// --------------------
	// reservation
	// --------------------

	// one owner at most
	a_one_owner: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(zw1 && zw2))
		else begin
			$error("zw1 and zw2 high together");
			err_cnt++;
		end

	// grant follows its request with one cycle of lag
	a_zw1_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		zw1 |-> (zg1 || $past(zg1)))
		else begin
			$error("zw1 high without zg1");
			err_cnt++;
		end

	a_zw2_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		zw2 |-> (zg2 || $past(zg2)))
		else begin
			$error("zw2 high without zg2");
			err_cnt++;
		end

	// --------------------
	// response and clear
	// --------------------

	// memory answers only while the bus is owned
	a_ok_owned: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ok |-> (zw1 || zw2))
		else begin
			$error("ok on a bus nobody owns");
			err_cnt++;
		end

	a_clm_free: assert property (@(posedge clk_sys) disable iff (!rst_n)
		clm |-> !(zw1 || zw2))
		else begin
			$error("grant held during clear");
			err_cnt++;
		end

endmodule

// attached to the interface switch
bind isk mera_bus_properties props_i (
	.clk_sys(clk_sys),
	.rst_n(rst_n),
	.clm(clm),
	.zg1(zg1),
	.zg2(zg2),
	.zw1(zw1),
	.zw2(zw2),
	.ok(mem_ok)
);

// ==== hw/mera_bus_top.sv ====
module mera_bus_top import mera_pkg::*; (
	input logic clk_sys,
	input logic rst_n,
	input logic clear,
	// processor port
	input logic cpu_req,
	input logic cpu_we,
	input seg_t cpu_nb,
	input bus_word_t cpu_ad,
	input bus_word_t cpu_dt,
	output logic cpu_busy,
	output logic cpu_done,
	output cyc_status_t cpu_status,
	output bus_word_t cpu_rdt,
	// channel port
	input logic ch_req,
	input logic ch_we,
	input seg_t ch_nb,
	input bus_word_t ch_ad,
	input bus_word_t ch_dt,
	output logic ch_busy,
	output logic ch_done,
	output cyc_status_t ch_status,
	output bus_word_t ch_rdt,
	output logic clm
);

	// --------------------
	// reservation
	// --------------------

	logic cpu_zg, cpu_zw, ch_zg, ch_zw;

	// --------------------
	// bus drivers
	// --------------------

	logic cpu_bw, cpu_br, ch_bw, ch_br;
	seg_t cpu_bnb, ch_bnb;
	bus_word_t cpu_bad, cpu_bdt, ch_bad, ch_bdt;

	// memory side and shared receivers
	logic mem_w, mem_r, mem_ok, bus_ok;
	seg_t mem_nb;
	bus_word_t mem_ad, mem_dt, mem_rdt, bus_rdt;

	puks puks_i (
		.clk_sys(clk_sys), .rst_n(rst_n), .clear(clear), .clm(clm)
	);

	// requester 1 has priority
	isk isk_i (
		.clk_sys(clk_sys), .rst_n(rst_n), .clm(clm),
		.zg1(cpu_zg), .zg2(ch_zg), .zw1(cpu_zw), .zw2(ch_zw),
		.w1(cpu_bw), .r1(cpu_br), .w2(ch_bw), .r2(ch_br),
		.nb1(cpu_bnb), .nb2(ch_bnb), .ad1(cpu_bad), .ad2(ch_bad),
		.dt1(cpu_bdt), .dt2(ch_bdt),
		.mem_w(mem_w), .mem_r(mem_r), .mem_nb(mem_nb), .mem_ad(mem_ad), .mem_dt(mem_dt),
		.mem_ok(mem_ok), .mem_rdt(mem_rdt), .ok(bus_ok), .rdt(bus_rdt)
	);

	bus_requester cpu_port_i (
		.clk_sys(clk_sys), .rst_n(rst_n), .clm(clm),
		.req(cpu_req), .we(cpu_we), .nb(cpu_nb), .ad(cpu_ad), .dt(cpu_dt),
		.busy(cpu_busy), .done(cpu_done), .status(cpu_status), .rdt(cpu_rdt),
		.zg(cpu_zg), .zw(cpu_zw),
		.bw(cpu_bw), .br(cpu_br), .bnb(cpu_bnb), .bad(cpu_bad), .bdt(cpu_bdt),
		.bok(bus_ok), .brdt(bus_rdt)
	);

	bus_requester ch_port_i (
		.clk_sys(clk_sys), .rst_n(rst_n), .clm(clm),
		.req(ch_req), .we(ch_we), .nb(ch_nb), .ad(ch_ad), .dt(ch_dt),
		.busy(ch_busy), .done(ch_done), .status(ch_status), .rdt(ch_rdt),
		.zg(ch_zg), .zw(ch_zw),
		.bw(ch_bw), .br(ch_br), .bnb(ch_bnb), .bad(ch_bad), .bdt(ch_bdt),
		.bok(bus_ok), .brdt(bus_rdt)
	);

	mem_module mem_i (
		.clk_sys(clk_sys), .rst_n(rst_n), .clm(clm),
		.w(mem_w), .r(mem_r), .nb(mem_nb), .ad(mem_ad), .dt(mem_dt),
		.ok(mem_ok), .rdt(mem_rdt)
	);

endmodule

// ==== hw/puks.sv ====
`include "mera_defs.svh"

module puks import mera_pkg::*; (
	input logic clk_sys,
	input logic rst_n,
	// panel clear pulse
	input logic clear,
	// bus clear
	output logic clm
);

	// ticks left in the clear period
	clr_cnt_t clr_cnt;

	// loaded at power-up and on each clear, then runs down
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			clr_cnt <= clr_cnt_t'(`PUKS_CLR_TICKS);
		end else if (clear) begin
			clr_cnt <= clr_cnt_t'(`PUKS_CLR_TICKS);
		end else if (clr_cnt != '0) begin
			clr_cnt <= clr_cnt - 1'b1;
		end
	end

	// held while the counter runs
	assign clm = (clr_cnt != '0);

endmodule

// ==== hw/mem_module.sv ====
`include "mera_defs.svh"

module mem_module import mera_pkg::*; (
	input logic clk_sys,
	input logic rst_n,
	input logic clm,
	// bus receivers
	input logic w,
	input logic r,
	input seg_t nb,
	input bus_word_t ad,
	input bus_word_t dt,
	// bus drivers
	output logic ok,
	output bus_word_t rdt
);

	localparam int WORDS = 2 ** `MEM_AW;
	localparam int SEG_W = (`MEM_SEGMENTS > 1) ? $clog2(`MEM_SEGMENTS) : 1;

	bus_word_t mem [`MEM_SEGMENTS][WORDS];
	logic hit;
	logic take;
	logic [SEG_W-1:0] sa;
	logic [`MEM_AW-1:0] wa;

	// silent outside fitted segments and pages
	assign hit = (w || r) && !clm && (nb < `MEM_SEGMENTS) && (ad < WORDS);
	// strobe is a level, answer it once
	assign take = hit && !ok;
	assign sa = nb[SEG_W-1:0];
	assign wa = ad[`MEM_AW-1:0];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			ok <= 1'b0;
		else
			ok <= take;
	end

	// array starts zeroed
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < `MEM_SEGMENTS; s++) begin
				for (int a = 0; a < WORDS; a++) begin
					mem[s][a] <= '0;
				end
			end
		end else if (take && w) begin
			mem[sa][wa] <= dt;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take && r && !w)
			rdt <= mem[sa][wa];
	end

endmodule

// ==== hw/bus_requester.sv ====
`include "mera_defs.svh"

module bus_requester import mera_pkg::*; (
	input logic clk_sys,
	input logic rst_n,
	input logic clm,
	// request side
	input logic req,
	input logic we,
	input seg_t nb,
	input bus_word_t ad,
	input bus_word_t dt,
	output logic busy,
	output logic done,
	output cyc_status_t status,
	output bus_word_t rdt,
	// reservation
	output logic zg,
	input logic zw,
	// bus drivers
	output logic bw,
	output logic br,
	output seg_t bnb,
	output bus_word_t bad,
	output bus_word_t bdt,
	// bus receivers
	input logic bok,
	input bus_word_t brdt
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RESERVE,
		ST_TRANSFER,
		ST_END
	} state_t;

	state_t state;
	tmo_cnt_t tmo_cnt;
	logic we_q;
	seg_t nb_q;
	bus_word_t ad_q;
	bus_word_t dt_q;
	logic accept;
	logic drive;
	logic answered;
	logic tmo_hit;

	// --------------------
	// request latch
	// --------------------

	// END is the cycle zw falls, new work may start there
	assign accept = req && !clm && (state == ST_IDLE || state == ST_END);

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			we_q <= we;
			nb_q <= nb;
			ad_q <= ad;
			dt_q <= dt;
		end
	end

	// --------------------
	// bus drivers
	// --------------------

	// strobes only while granted, isk gates the rest
	assign drive = zw && (state == ST_RESERVE || state == ST_TRANSFER);
	assign bw = drive && we_q;
	assign br = drive && !we_q;
	assign bnb = nb_q;
	assign bad = ad_q;
	assign bdt = dt_q;

	assign answered = (state == ST_TRANSFER) && bok && zw;
	assign tmo_hit = (state == ST_TRANSFER) && (tmo_cnt == tmo_cnt_t'(`BUS_TIMEOUT_TICKS - 1));

	// --------------------
	// cycle FSM
	// --------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			zg <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			status <= CYC_OK;
			tmo_cnt <= '0;
		end else if (clm) begin
			// abort, no done
			state <= ST_IDLE;
			zg <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			tmo_cnt <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE, ST_END: begin
					state <= ST_IDLE;
					if (accept) begin
						state <= ST_RESERVE;
						zg <= 1'b1;
						busy <= 1'b1;
					end
				end
				ST_RESERVE: begin
					// wait for zw with no limit
					tmo_cnt <= '0;
					if (zw)
						state <= ST_TRANSFER;
				end
				ST_TRANSFER: begin
					if (answered || tmo_hit) begin
						status <= answered ? CYC_OK : CYC_ALARM;
						done <= 1'b1;
						busy <= 1'b0;
						zg <= 1'b0;
						state <= ST_END;
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// read data on a good read, zero for writes and alarms
	always_ff @(posedge clk_sys) begin
		if (!clm && (answered || tmo_hit))
			rdt <= (answered && !we_q) ? brdt : '0;
	end

endmodule

// ==== hw/isk.sv ====
module isk import mera_pkg::*; (
	input logic clk_sys,
	input logic rst_n,
	input logic clm,
	// reservation
	input logic zg1,
	input logic zg2,
	output logic zw1,
	output logic zw2,
	// requester drivers
	input logic w1,
	input logic r1,
	input logic w2,
	input logic r2,
	input seg_t nb1,
	input seg_t nb2,
	input bus_word_t ad1,
	input bus_word_t ad2,
	input bus_word_t dt1,
	input bus_word_t dt2,
	// memory side
	output logic mem_w,
	output logic mem_r,
	output seg_t mem_nb,
	output bus_word_t mem_ad,
	output bus_word_t mem_dt,
	input logic mem_ok,
	input bus_word_t mem_rdt,
	// receivers back to requesters
	output logic ok,
	output bus_word_t rdt
);

	typedef enum logic [1:0] {
		RES_FREE,
		RES_OWN1,
		RES_OWN2
	} res_t;

	res_t res;
	res_t res_nxt;

	// fixed priority, requester 1 wins a free bus
	always_comb begin
		res_nxt = res;
		case (res)
			RES_FREE: begin
				if (zg1)
					res_nxt = RES_OWN1;
				else if (zg2)
					res_nxt = RES_OWN2;
			end
			RES_OWN1: begin
				if (!zg1)
					res_nxt = RES_FREE;
			end
			RES_OWN2: begin
				if (!zg2)
					res_nxt = RES_FREE;
			end
			default: res_nxt = RES_FREE;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			res <= RES_FREE;
		else if (clm)
			res <= RES_FREE;
		else
			res <= res_nxt;
	end

	// grants, dropped at once by clear
	assign zw1 = (res == RES_OWN1) && !clm;
	assign zw2 = (res == RES_OWN2) && !clm;

	// drivers gated by grant, then wired-or onto memory receivers
	assign mem_w = (w1 & zw1) | (w2 & zw2);
	assign mem_r = (r1 & zw1) | (r2 & zw2);
	assign mem_nb = (nb1 & {$bits(seg_t){zw1}}) | (nb2 & {$bits(seg_t){zw2}});
	assign mem_ad = (ad1 & {$bits(bus_word_t){zw1}}) | (ad2 & {$bits(bus_word_t){zw2}});
	assign mem_dt = (dt1 & {$bits(bus_word_t){zw1}}) | (dt2 & {$bits(bus_word_t){zw2}});

	// answer only reaches the bus while someone owns it
	assign ok = mem_ok & (zw1 | zw2);
	assign rdt = mem_rdt;

endmodule

// ==== hw/mera_pkg.sv ====
`include "mera_defs.svh"

package mera_pkg;

	// one bus word, both address and data
	typedef logic [15:0] bus_word_t;

	// nb field, memory segment number
	typedef logic [3:0] seg_t;

	// end of a bus cycle
	typedef enum logic {
		CYC_OK,
		CYC_ALARM
	} cyc_status_t;

	// counters
	// clear period, holds PUKS_CLR_TICKS down to zero
	typedef logic [$clog2(`PUKS_CLR_TICKS + 1)-1:0] clr_cnt_t;

	// no-answer timer while holding the bus
	typedef logic [$clog2(`BUS_TIMEOUT_TICKS + 1)-1:0] tmo_cnt_t;

endpackage

// ==== hw/mera_defs.svh ====
`ifndef MERA_DEFS_SVH
`define MERA_DEFS_SVH

// --------------------
// memory geometry
// --------------------

// word address bits inside one segment
`define MEM_AW 8
// segments fitted, numbered from 0
`define MEM_SEGMENTS 2

// --------------------
// timing
// --------------------

// clear period after power-up or panel clear
`define PUKS_CLR_TICKS 16
// cycles without ok before the alarm
`define BUS_TIMEOUT_TICKS 32

`endif
